//--- project.f
+incdir+.
kronosTypes.sv
kronosId0.sv
kronosDecode.sv
kronosScoreboard.sv
kronosFrontEnd.sv
kronosFrontEndTb.sv

//--- run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module kronosFrontEndTb -f project.f -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1

//--- kronosRefModel.svh
/*
  Kronos front end reference model
*/
`ifndef KRONOS_REF_MODEL_SVH
`define KRONOS_REF_MODEL_SVH

// Immediate by instruction format, straight from the ISA layout
function automatic logic [31:0] refImmediate(input logic [31:0] i);
  case (i[6:2])
    INSTR_OPIMM, INSTR_LOAD, INSTR_JALR: return {{20{i[31]}}, i[31:20]};
    INSTR_STORE: return {{20{i[31]}}, i[31:25], i[11:7]};
    INSTR_BR:    return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
    INSTR_LUI, INSTR_AUIPC: return {i[31:12], 12'd0};
    INSTR_JAL:   return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
    default:     return 32'd0;
  endcase
endfunction

// Coarse ALU class
function automatic aluClass_t refAluClass(input logic [31:0] i);
  if (i[6:2] == INSTR_LUI) return ALU_PASS;
  if (i[6:2] == INSTR_BR) return ALU_BRANCH;
  if (i[6:2] == INSTR_OP || i[6:2] == INSTR_OPIMM) begin
    case (i[14:12])
      3'd0:       return ALU_ADD;
      3'd1, 3'd5: return ALU_SHIFT;
      3'd2, 3'd3: return ALU_COMPARE;
      default:    return ALU_LOGIC;
    endcase
  end
  return ALU_ADD;
endfunction

// Register read flags
function automatic bit rs1Reads(input logic [31:0] i);
  return i[6:2] inside {INSTR_OPIMM, INSTR_OP, INSTR_JALR, INSTR_BR, INSTR_LOAD, INSTR_STORE};
endfunction

function automatic bit rs2Reads(input logic [31:0] i);
  return i[6:2] inside {INSTR_OP, INSTR_BR, INSTR_STORE};
endfunction

// Expected execute packet from the word, PC and current register values
function automatic decodePkt_t refPacket(input logic [31:0] i, input logic [31:0] pc,
                                         input logic [31:0] r1, input logic [31:0] r2);
  decodePkt_t p;
  p.op1       = (i[6:2] == INSTR_AUIPC || i[6:2] == INSTR_JAL) ? pc : r1;
  p.op2       = (i[6:2] == INSTR_OP) ? r2 : refImmediate(i);
  p.storeData = r2;
  p.rd        = i[11:7];
  p.rdWrite   = !(i[6:2] == INSTR_STORE || i[6:2] == INSTR_BR || i[11:7] == 5'd0);
  p.aluOp     = refAluClass(i);
  p.opcode    = i[6:2];
  return p;
endfunction

`endif

//--- kronosFrontEndTb.sv
/*
  Kronos front end testbench
*/
`timescale 1ns/1ps

module kronosFrontEndTb;
  import kronosTypes::*;

  `include "kronosRefModel.svh"

  localparam int NUM_MIX    = 150;
  localparam int NUM_HAZARD = 150;
  // 20 cycles per instruction plus slack for reset and register fill
  localparam int WATCHDOG_CYCLES = (NUM_MIX + NUM_HAZARD) * 20 + 200;
  localparam logic [4:0] OPS [9] = '{INSTR_LOAD, INSTR_OPIMM, INSTR_AUIPC, INSTR_STORE,
                                     INSTR_OP, INSTR_LUI, INSTR_BR, INSTR_JALR, INSTR_JAL};

  typedef struct {
    fetchPkt_t f;
    int        acceptCycle;
    int        stallMark;
    int        phase;
  } accepted_t;

  logic       clk;
  logic       rst;
  fetchPkt_t  fetch;
  logic       fetchValid;
  logic       fetchStall;
  wbPkt_t     wb;
  decodePkt_t decoded;
  logic       decodeValid;

  int          seed = 32'hd2bd7cf2;
  int          wbSeed = 32'hd2bd7cf2 ^ 32'h13579bdf;
  int          errors = 0;
  int          sentCnt = 0;
  int          issuedCnt = 0;
  int          stallCnt = 0;
  int          phase = 0;
  bit          fillDone = 0;
  logic [31:0] pcNext = 32'h0000_1000;
  logic [31:0] shadowRegs [REG_COUNT];
  // Registers issued with a write that has not come back yet
  bit [REG_COUNT-1:0] pendSet = '0;
  accepted_t   acceptQ [$];
  logic [4:0]  pendQ [$];
  string       phaseNames [2] = '{"random_mix", "hazard_mix"};

  kronosFrontEnd u_dut (
    .clk         (clk),
    .rst         (rst),
    .fetch       (fetch),
    .fetchValid  (fetchValid),
    .fetchStall  (fetchStall),
    .wb          (wb),
    .decoded     (decoded),
    .decodeValid (decodeValid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  task automatic checkField(input string test, input string field,
                            input logic [31:0] expVal, input logic [31:0] actVal);
    assert (expVal === actVal) else begin
      $display("MISMATCH %s %s expected %h actual %h", test, field, expVal, actVal);
      errors++;
    end
  endtask

  // Source read by the word still waiting on its write-back
  function automatic bit sourcePending(input logic [31:0] i);
    logic [4:0] r1;
    logic [4:0] r2;
    bit         busy1;
    bit         busy2;
    r1 = i[19:15];
    r2 = i[24:20];
    busy1 = rs1Reads(i) && r1 != 5'd0 && pendSet[r1] && !(wb.en && wb.sel == r1);
    busy2 = rs2Reads(i) && r2 != 5'd0 && pendSet[r2] && !(wb.en && wb.sel == r2);
    return busy1 || busy2;
  endfunction

  // Random word with a legal opcode, narrow keeps registers in x1..x7
  function automatic logic [31:0] makeInstr(input bit narrow);
    logic [31:0] w;
    int          idx;
    w = $random(seed);
    idx = int'($unsigned($random(seed)) % 9);
    w[6:0] = {OPS[idx], 2'b11};
    if (narrow) begin
      w[11:7]  = 5'(($unsigned($random(seed)) % 7) + 1);
      w[19:15] = 5'(($unsigned($random(seed)) % 7) + 1);
      w[24:20] = 5'(($unsigned($random(seed)) % 7) + 1);
    end
    return w;
  endfunction

  // Present one word and wait for acceptance
  task automatic sendInstr(input logic [31:0] word);
    fetch      <= '{pc: pcNext, instr: word};
    fetchValid <= 1'b1;
    @(posedge clk);
    while (fetchStall) @(posedge clk);
    pcNext += 4;
    sentCnt++;
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial begin
    logic [31:0] d;
    rst = 1'b1;
    fetchValid = 1'b0;
    fetch = '0;
    wb = '0;
    for (int r = 0; r < REG_COUNT; r++) shadowRegs[r] = 32'd0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // Fill x1..x31 through the write-back port
    for (int r = 1; r < REG_COUNT; r++) begin
      d = $random(seed);
      wb <= '{data: d, sel: 5'(r), en: 1'b1};
      shadowRegs[r] <= d;
      @(posedge clk);
    end
    wb.en <= 1'b0;
    fillDone = 1;
    for (int p = 0; p < 2; p++) begin
      phase = p;
      for (int n = 0; n < (p == 0 ? NUM_MIX : NUM_HAZARD); n++) begin
        if (($random(seed) & 15) == 0) begin
          fetchValid <= 1'b0;
          @(posedge clk);
        end
        sendInstr(makeInstr(p == 1));
      end
    end
    fetchValid <= 1'b0;
    while (issuedCnt < sentCnt || pendQ.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    assert (acceptQ.size() == 0) else begin
      $display("Accepted fetches left without a decodeValid: %0d", acceptQ.size());
      errors++;
    end
    assert (stallCnt > 0) else begin
      $display("No fetchStall seen although hazards were generated");
      errors++;
    end
    $display("errors: %0d issued: %0d stall cycles: %0d", errors, issuedCnt, stallCnt);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // ==========================================================================
  // Write-back driver
  // ==========================================================================

  initial begin
    int          delay;
    logic [4:0]  rd;
    logic [31:0] d;
    delay = 0;
    wait (fillDone);
    forever begin
      @(posedge clk);
      if (decodeValid && decoded.rdWrite) pendQ.push_back(decoded.rd);
      if (pendQ.size() != 0 && delay == 0) begin
        rd = pendQ.pop_front();
        d = $random(wbSeed);
        wb <= '{data: d, sel: rd, en: 1'b1};
        // Shadow holds the new value while it sits on wb
        shadowRegs[rd] <= d;
        delay = int'($unsigned($random(wbSeed)) % 8);
      end else begin
        wb.en <= 1'b0;
        if (delay > 0) delay--;
      end
    end
  end

  // ==========================================================================
  // Compare process
  // ==========================================================================

  always @(posedge clk) begin
    static int cycleCnt = 0;
    static bit prevRst = 0;
    accepted_t          a;
    decodePkt_t         e;
    string              t;
    bit [REG_COUNT-1:0] setBits;
    cycleCnt++;
    setBits = '0;
    // Outputs during reset and first cycle after
    if (prevRst) begin
      assert (decodeValid === 1'b0 && fetchStall === 1'b0) else begin
        $display("decodeValid or fetchStall not low around reset");
        errors++;
      end
    end
    prevRst = rst;
    if (!rst && fetchValid && !fetchStall) begin
      acceptQ.push_back('{f: fetch, acceptCycle: cycleCnt, stallMark: stallCnt, phase: phase});
    end
    if (!rst && decodeValid) begin
      if (acceptQ.size() == 0) begin
        $display("decodeValid with no accepted fetch outstanding");
        errors++;
      end else begin
        a = acceptQ.pop_front();
        t = phaseNames[a.phase];
        e = refPacket(a.f.instr, a.f.pc, shadowRegs[a.f.instr[19:15]],
                      shadowRegs[a.f.instr[24:20]]);
        checkField(t, "op1", e.op1, decoded.op1);
        checkField(t, "op2", e.op2, decoded.op2);
        if (rs2Reads(a.f.instr)) checkField(t, "storeData", e.storeData, decoded.storeData);
        checkField(t, "rd", 32'(e.rd), 32'(decoded.rd));
        checkField(t, "rdWrite", 32'(e.rdWrite), 32'(decoded.rdWrite));
        checkField(t, "aluOp", 32'(e.aluOp), 32'(decoded.aluOp));
        checkField(t, "opcode", 32'(e.opcode), 32'(decoded.opcode));
        // Two cycles plus one per stalled cycle in between
        checkField(t, "latency", 32'(2 + stallCnt - a.stallMark),
                   32'(cycleCnt - a.acceptCycle));
        assert (!sourcePending(a.f.instr)) else begin
          $display("Instruction at pc %h issued while a source write was outstanding",
                   a.f.pc);
          errors++;
        end
        if (e.rdWrite) setBits[e.rd] = 1'b1;
        issuedCnt++;
      end
    end
    if (!rst && fetchStall) begin
      stallCnt++;
      // Oldest accepted word is the one held in decode
      assert (acceptQ.size() != 0 && sourcePending(acceptQ[0].f.instr)) else begin
        $display("fetchStall high with no outstanding source write for the held word");
        errors++;
      end
    end
    // A clear wins over a set of the same register
    if (!rst) begin
      pendSet = pendSet | setBits;
      if (wb.en) pendSet[wb.sel] = 1'b0;
    end
  end

  // ==========================================================================
  // Watchdog
  // ==========================================================================

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, %0d of %0d issued", WATCHDOG_CYCLES,
             issuedCnt, sentCnt);
    errors++;
    $display("errors: %0d issued: %0d stall cycles: %0d", errors, issuedCnt, stallCnt);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- kronosFrontEnd.sv
/*
  Kronos operand front end
*/
`timescale 1ns/1ps

module kronosFrontEnd (
  input  logic                    clk,
  input  logic                    rst,
  input  kronosTypes::fetchPkt_t  fetch,
  input  logic                    fetchValid,
  output logic                    fetchStall,
  input  kronosTypes::wbPkt_t     wb,
  output kronosTypes::decodePkt_t decoded,
  output logic                    decodeValid
);
  import kronosTypes::*;

  id0Pkt_t    id0Pkt;
  logic       id0Valid;
  logic       load;
  logic       stall;
  logic [4:0] rs1Sel;
  logic [4:0] rs2Sel;
  logic       rs1En;
  logic       rs2En;
  logic       holdValid;

  // Whole front end freezes on a hazard
  assign load       = fetchValid && !stall;
  assign fetchStall = stall;

  // ==========================================================================
  // Stages
  // ==========================================================================

  kronosId0 u_id0 (
    .clk      (clk),
    .rst      (rst),
    .load     (load),
    .fetch    (fetch),
    .wb       (wb),
    .id0Out   (id0Pkt),
    .id0Valid (id0Valid)
  );

  kronosDecode u_decode (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .id0In       (id0Pkt),
    .id0Valid    (id0Valid),
    .wb          (wb),
    .rs1Sel      (rs1Sel),
    .rs2Sel      (rs2Sel),
    .rs1En       (rs1En),
    .rs2En       (rs2En),
    .holdValid   (holdValid),
    .decoded     (decoded),
    .decodeValid (decodeValid)
  );

  // Issue side taken from the outgoing packet
  kronosScoreboard u_scoreboard (
    .clk        (clk),
    .rst        (rst),
    .rs1Sel     (rs1Sel),
    .rs2Sel     (rs2Sel),
    .rs1En      (rs1En),
    .rs2En      (rs2En),
    .holdValid  (holdValid),
    .issueRd    (decoded.rd),
    .issueWrite (decoded.rdWrite),
    .issue      (decodeValid),
    .wb         (wb),
    .stall      (stall)
  );

endmodule

//--- kronosScoreboard.sv
/*
  Kronos RAW scoreboard
*/
`timescale 1ns/1ps

module kronosScoreboard (
  input  logic                clk,
  input  logic                rst,
  input  logic [4:0]          rs1Sel,
  input  logic [4:0]          rs2Sel,
  input  logic                rs1En,
  input  logic                rs2En,
  input  logic                holdValid,
  input  logic [4:0]          issueRd,
  input  logic                issueWrite,
  input  logic                issue,
  input  kronosTypes::wbPkt_t wb,
  output logic                stall
);
  import kronosTypes::*;

  // One bit per register with a write in flight
  logic [REG_COUNT-1:0] pending;
  logic [REG_COUNT-1:0] setMask;
  logic [REG_COUNT-1:0] clrMask;
  logic                 rs1Hit;
  logic                 rs2Hit;

  // ==========================================================================
  // Pending bitmap
  // ==========================================================================

  // x0 never becomes pending
  assign setMask = (issue && issueWrite && issueRd != 5'd0) ?
                   (REG_COUNT'(1) << issueRd) : '0;
  assign clrMask = wb.en ? (REG_COUNT'(1) << wb.sel) : '0;

  // Clear applied last so it wins on a collision
  always_ff @(posedge clk) begin
    if (rst) pending <= '0;
    else pending <= (pending | setMask) & ~clrMask;
  end

  // ==========================================================================
  // Hazard detect
  // ==========================================================================

  // A source being written back right now is already covered by decode
  assign rs1Hit = rs1En && rs1Sel != 5'd0 && pending[rs1Sel] &&
                  !(wb.en && wb.sel == rs1Sel);
  assign rs2Hit = rs2En && rs2Sel != 5'd0 && pending[rs2Sel] &&
                  !(wb.en && wb.sel == rs2Sel);

  assign stall = holdValid && (rs1Hit || rs2Hit);

endmodule

//--- kronosDecode.sv
/*
  Kronos main decode stage
*/
`timescale 1ns/1ps

module kronosDecode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    stall,
  input  kronosTypes::id0Pkt_t    id0In,
  input  logic                    id0Valid,
  input  kronosTypes::wbPkt_t     wb,
  output logic [4:0]              rs1Sel,
  output logic [4:0]              rs2Sel,
  output logic                    rs1En,
  output logic                    rs2En,
  output logic                    holdValid,
  output kronosTypes::decodePkt_t decoded,
  output logic                    decodeValid
);
  import kronosTypes::*;

  id0Pkt_t     hold;
  logic        id0Waiting;
  logic        inValid;
  logic        take;
  logic [4:0]  opcode;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic [31:0] rs1Val;
  logic [31:0] rs2Val;
  aluClass_t   aluOp;

  // Write-back wins over held data for a matching nonzero source
  function automatic logic [31:0] snoop(input logic [4:0] sel, input logic [31:0] data,
                                        input wbPkt_t w);
    if (w.en && w.sel == sel && sel != 5'd0) return w.data;
    return data;
  endfunction

  // ==========================================================================
  // Hold register
  // ==========================================================================

  // Stage-0 keeps its word through a stall, remember it is still there
  assign inValid = id0Valid || id0Waiting;
  // Free when empty or issuing this cycle
  assign take    = !holdValid || !stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      holdValid  <= 1'b0;
      id0Waiting <= 1'b0;
    end else if (take) begin
      holdValid  <= inValid;
      id0Waiting <= 1'b0;
    end else begin
      id0Waiting <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      hold         <= id0In;
      // Stage-0 patches itself at this same edge, too late for us
      hold.rs1Data <= snoop(id0In.instr[19:15], id0In.rs1Data, wb);
      hold.rs2Data <= snoop(id0In.instr[24:20], id0In.rs2Data, wb);
    end else begin
      // Stalled, fold in any write-back that lands meanwhile
      hold.rs1Data <= rs1Val;
      hold.rs2Data <= rs2Val;
    end
  end

  // ==========================================================================
  // Field aliases and source operands
  // ==========================================================================

  assign opcode = hold.instr[6:2];
  assign rd     = hold.instr[11:7];
  assign funct3 = hold.instr[14:12];
  assign rs1Sel = hold.instr[19:15];
  assign rs2Sel = hold.instr[24:20];
  assign rs1En  = hold.rs1En;
  assign rs2En  = hold.rs2En;

  // Same-cycle write-back is what releases the stall
  assign rs1Val = snoop(rs1Sel, hold.rs1Data, wb);
  assign rs2Val = snoop(rs2Sel, hold.rs2Data, wb);

  // ==========================================================================
  // Execute packet
  // ==========================================================================

  always_comb begin
    case (opcode)
      INSTR_LUI: aluOp = ALU_PASS;
      INSTR_BR:  aluOp = ALU_BRANCH;
      INSTR_OP, INSTR_OPIMM: begin
        case (funct3)
          3'd0:       aluOp = ALU_ADD;
          3'd1, 3'd5: aluOp = ALU_SHIFT;
          3'd2, 3'd3: aluOp = ALU_COMPARE;
          default:    aluOp = ALU_LOGIC;
        endcase
      end
      // Address and link arithmetic
      default:   aluOp = ALU_ADD;
    endcase
  end

  always_comb begin
    decoded.op1       = (opcode == INSTR_AUIPC || opcode == INSTR_JAL) ? hold.pc : rs1Val;
    decoded.op2       = (opcode == INSTR_OP) ? rs2Val : hold.immediate;
    decoded.storeData = rs2Val;
    decoded.rd        = rd;
    // Stores and branches have no rd, x0 writes are dropped
    decoded.rdWrite   = opcode != INSTR_STORE && opcode != INSTR_BR && rd != 5'd0;
    decoded.aluOp     = aluOp;
    decoded.opcode    = opcode;
  end

  // One cycle per issued instruction
  assign decodeValid = holdValid && !stall;

endmodule

//--- kronosId0.sv
/*
  Kronos stage-0 decoder
*/
`timescale 1ns/1ps

module kronosId0 (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load,
  input  kronosTypes::fetchPkt_t fetch,
  input  kronosTypes::wbPkt_t    wb,
  output kronosTypes::id0Pkt_t   id0Out,
  output logic                   id0Valid
);
  import kronosTypes::*;

  logic [31:0] instr;
  logic [4:0]  opcode;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  funct3;
  logic        sign;

  // Instruction formats
  logic fmtI;
  logic fmtS;
  logic fmtB;
  logic fmtU;
  logic fmtJ;

  // Immediate segments, A is bit 0 up to F at [31:20]
  logic        immA;
  logic [3:0]  immB;
  logic [5:0]  immC;
  logic        immD;
  logic [7:0]  immE;
  logic [11:0] immF;

  logic        csrRead;
  logic        rs1Read;
  logic        rs2Read;
  logic [31:0] rs1Fwd;
  logic [31:0] rs2Fwd;

  logic [31:0] regs [REG_COUNT];

  // ==========================================================================
  // Field aliases
  // ==========================================================================

  assign instr  = fetch.instr;
  assign opcode = instr[6:2];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct3 = instr[14:12];
  assign sign   = instr[31];

  // ==========================================================================
  // Immediate decode
  // ==========================================================================

  always_comb begin
    fmtI = opcode == INSTR_OPIMM || opcode == INSTR_LOAD || opcode == INSTR_JALR;
    fmtS = opcode == INSTR_STORE;
    fmtB = opcode == INSTR_BR;
    fmtU = opcode == INSTR_LUI || opcode == INSTR_AUIPC;
    fmtJ = opcode == INSTR_JAL;

    // Bit 0, only I and S carry it
    immA = fmtI ? instr[20] : (fmtS ? instr[7] : 1'b0);

    // Bits 4:1
    if (fmtU) immB = 4'd0;
    else if (fmtI || fmtJ) immB = instr[24:21];
    else immB = instr[11:8];

    // Bits 10:5, shared by all but U
    immC = fmtU ? 6'd0 : instr[30:25];

    // Bit 11 moves around the most
    if (fmtU) immD = 1'b0;
    else if (fmtB) immD = instr[7];
    else if (fmtJ) immD = instr[20];
    else immD = sign;

    // Upper bits come straight from the word for U and J
    immE = (fmtU || fmtJ) ? instr[19:12] : {8{sign}};
    immF = fmtU ? instr[31:20] : {12{sign}};
  end

  // ==========================================================================
  // Register file
  // ==========================================================================

  // x0 may be written, reads of it are forced to zero
  always_ff @(posedge clk) begin
    if (wb.en) regs[wb.sel] <= wb.data;
  end

  // Read ports with write-back bypass at the load edge
  always_comb begin
    rs1Fwd = regs[rs1];
    if (wb.en && wb.sel == rs1) rs1Fwd = wb.data;
    if (rs1 == 5'd0) rs1Fwd = '0;

    rs2Fwd = regs[rs2];
    if (wb.en && wb.sel == rs2) rs2Fwd = wb.data;
    if (rs2 == 5'd0) rs2Fwd = '0;
  end

  // ==========================================================================
  // Register read flags
  // ==========================================================================

  // CSRRW/CSRRS/CSRRC, immediate forms read no register
  assign csrRead = opcode == INSTR_SYS && funct3 inside {3'b001, 3'b010, 3'b011};

  assign rs1Read = opcode inside {INSTR_OPIMM, INSTR_OP, INSTR_JALR, INSTR_BR,
                                  INSTR_LOAD, INSTR_STORE} || csrRead;
  assign rs2Read = opcode inside {INSTR_OP, INSTR_BR, INSTR_STORE};

  // ==========================================================================
  // Output register
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (load) begin
      id0Out.pc        <= fetch.pc;
      id0Out.instr     <= instr;
      id0Out.immediate <= {immF, immE, immD, immC, immB, immA};
      id0Out.rs1Data   <= rs1Fwd;
      id0Out.rs2Data   <= rs2Fwd;
      id0Out.rs1En     <= rs1Read;
      id0Out.rs2En     <= rs2Read;
    end else begin
      // Held word under stall keeps up with write-back
      if (wb.en && wb.sel == id0Out.instr[19:15] && wb.sel != 5'd0) begin
        id0Out.rs1Data <= wb.data;
      end
      if (wb.en && wb.sel == id0Out.instr[24:20] && wb.sel != 5'd0) begin
        id0Out.rs2Data <= wb.data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) id0Valid <= 1'b0;
    else id0Valid <= load;
  end

endmodule

//--- kronosTypes.sv
/*
  Kronos front end shared types
*/
package kronosTypes;

  // ==========================================================================
  // Major opcodes
  // ==========================================================================

  // instr[6:2], the low two bits are always 2'b11 for RV32I
  localparam logic [4:0] INSTR_LOAD  = 5'b00_000;
  localparam logic [4:0] INSTR_OPIMM = 5'b00_100;
  localparam logic [4:0] INSTR_AUIPC = 5'b00_101;
  localparam logic [4:0] INSTR_STORE = 5'b01_000;
  localparam logic [4:0] INSTR_OP    = 5'b01_100;
  localparam logic [4:0] INSTR_LUI   = 5'b01_101;
  localparam logic [4:0] INSTR_BR    = 5'b11_000;
  localparam logic [4:0] INSTR_JALR  = 5'b11_001;
  localparam logic [4:0] INSTR_JAL   = 5'b11_011;
  localparam logic [4:0] INSTR_SYS   = 5'b11_100;

  // Integer register file depth
  localparam int REG_COUNT = 32;

  // ==========================================================================
  // ALU operation class
  // ==========================================================================

  // Coarse class only, execute refines it with funct3/funct7
  typedef enum logic [2:0] {
    ALU_ADD     = 3'd0,
    ALU_LOGIC   = 3'd1,
    ALU_SHIFT   = 3'd2,
    ALU_COMPARE = 3'd3,
    ALU_BRANCH  = 3'd4,
    ALU_PASS    = 3'd5
  } aluClass_t;

  // ==========================================================================
  // Stage packets
  // ==========================================================================

  // From fetch
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fetchPkt_t;

  // Registered output of stage-0
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] immediate;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic        rs1En;
    logic        rs2En;
  } id0Pkt_t;

  // Issued to execute
  typedef struct packed {
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] storeData;
    logic [4:0]  rd;
    logic        rdWrite;
    aluClass_t   aluOp;
    logic [4:0]  opcode;
  } decodePkt_t;

  // Register write-back port
  typedef struct packed {
    logic [31:0] data;
    logic [4:0]  sel;
    logic        en;
  } wbPkt_t;

endpackage
